//--- Bender.yml
package:
  name: keccak

sources:
  - files:
      - rtl/keccak_pkg.sv
      - rtl/padder.sv
      - rtl/keccak_round.sv
      - rtl/f_permutation.sv
      - rtl/keccak.sv
  - target: test
    files:
      - tests/keccak_checker.sv
      - tests/tb_keccak.sv

//--- project.f
rtl/keccak_pkg.sv
rtl/padder.sv
rtl/keccak_round.sv
rtl/f_permutation.sv
rtl/keccak.sv
tests/keccak_checker.sv
tests/tb_keccak.sv

//--- rtl/f_permutation.sv
/* keccak-f[1600] permutation unit: block absorb into the rate,
   24 iterated rounds and a completion pulse. */
`timescale 1ns/1ps

module f_permutation
  import keccak_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  block_t block,
  input  logic   block_ready,
  output logic   ack,
  output state_t state,
  output logic   state_ready
);

  logic       busy_q;
  round_idx_t round_q;
  state_t     round_out;
  word_t      rc;

  // take a block as soon as it is seen while idle.
  assign ack = block_ready && !busy_q;

  assign rc = round_constant(round_q);

  keccak_round i_round (
    .in_state    (state),
    .round_const (rc),
    .out_state   (round_out)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy_q      <= 1'b0;
      round_q     <= '0;
      state       <= '0;
      state_ready <= 1'b0;
    end
    else
    begin
      state_ready <= 1'b0;
      if (ack)
      begin
        // xor into the rate, capacity untouched.
        state   <= state ^ {block, {capacity_bits{1'b0}}};
        busy_q  <= 1'b1;
        round_q <= '0;
      end
      else if (busy_q)
      begin
        state <= round_out;
        if (round_q == round_idx_t'(num_rounds - 1))
        begin
          // last round written, result valid next cycle.
          busy_q      <= 1'b0;
          round_q     <= '0;
          state_ready <= 1'b1;
        end
        else
        begin
          round_q <= round_q + 5'd1;
        end
      end
    end
  end

  // no new block during the 24 round cycles.
  assert property (@(posedge clk) disable iff (reset)
    ack |=> !ack [*num_rounds]);

  assert property (@(posedge clk) disable iff (reset)
    round_q < round_idx_t'(num_rounds));

  // completion comes exactly 25 cycles after the absorb.
  assert property (@(posedge clk) disable iff (reset)
    ack |-> ##(num_rounds + 1) state_ready);

endmodule

//--- rtl/keccak.sv
/* keccak-512 top: padder and permutation, byte order swap
   between stream and lanes, digest valid flag. */
`timescale 1ns/1ps

module keccak
  import keccak_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  word_t     in,
  input  logic      in_ready,
  input  logic      is_last,
  input  byte_cnt_t byte_num,
  output logic      buffer_full,
  output digest_t   out,
  output logic      out_ready
);

  block_t  pad_block;
  block_t  lane_block;
  logic    block_ready;
  logic    final_block;
  logic    ack;
  state_t  state;
  logic    state_ready;
  logic    last_taken;
  digest_t lane_digest;

  // stream words are big-endian, keccak lanes little-endian.
  function automatic word_t swap_bytes(word_t w);
    return {<<8{w}};
  endfunction

  always_comb
  begin
    for (int w = 0; w < block_words; w++)
      lane_block[64*w +: 64] = swap_bytes(pad_block[64*w +: 64]);
  end

  // digest is the leading lanes of the state.
  assign lane_digest = state[rate_bits+capacity_bits-1 -: digest_bits];

  always_comb
  begin
    for (int w = 0; w < digest_bits / 64; w++)
      out[64*w +: 64] = swap_bytes(lane_digest[64*w +: 64]);
  end

  padder i_padder (
    .clk         (clk),
    .reset       (reset),
    .in          (in),
    .in_ready    (in_ready),
    .is_last     (is_last),
    .byte_num    (byte_num),
    .buffer_full (buffer_full),
    .block       (pad_block),
    .block_ready (block_ready),
    .final_block (final_block),
    .ack         (ack)
  );

  f_permutation i_f_permutation (
    .clk         (clk),
    .reset       (reset),
    .block       (lane_block),
    .block_ready (block_ready),
    .ack         (ack),
    .state       (state),
    .state_ready (state_ready)
  );

  // final block absorbed, next completion is the digest.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      last_taken <= 1'b0;
      out_ready  <= 1'b0;
    end
    else
    begin
      if (final_block && ack)
        last_taken <= 1'b1;
      if (last_taken && state_ready)
        out_ready <= 1'b1;
    end
  end

  // sticky until reset.
  assert property (@(posedge clk) disable iff (reset)
    out_ready |=> out_ready);

endmodule

//--- rtl/keccak_pkg.sv
/* keccak core sizes, vector types, round constant table
   and the padder state encoding. */
package keccak_pkg;

  // fixed keccak-f[1600] configuration.
  localparam int unsigned rate_bits     = 576;
  localparam int unsigned capacity_bits = 1024;
  localparam int unsigned digest_bits   = 512;
  localparam int unsigned block_words   = rate_bits / 64;
  localparam int unsigned num_rounds    = 24;

  typedef logic [63:0]                        word_t;
  typedef logic [2:0]                         byte_cnt_t;
  typedef logic [rate_bits-1:0]               block_t;
  typedef logic [rate_bits+capacity_bits-1:0] state_t;
  typedef logic [digest_bits-1:0]             digest_t;
  typedef logic [4:0]                         round_idx_t;

  // padder phases.
  typedef enum logic [1:0] {
    collecting,
    padding,
    offering,
    done
  } padder_state_e;

  // iota constants, one per round.
  function automatic word_t round_constant(round_idx_t idx);
    case (idx)
      5'd0:    return 64'h0000_0000_0000_0001;
      5'd1:    return 64'h0000_0000_0000_8082;
      5'd2:    return 64'h8000_0000_0000_808a;
      5'd3:    return 64'h8000_0000_8000_8000;
      5'd4:    return 64'h0000_0000_0000_808b;
      5'd5:    return 64'h0000_0000_8000_0001;
      5'd6:    return 64'h8000_0000_8000_8081;
      5'd7:    return 64'h8000_0000_0000_8009;
      5'd8:    return 64'h0000_0000_0000_008a;
      5'd9:    return 64'h0000_0000_0000_0088;
      5'd10:   return 64'h0000_0000_8000_8009;
      5'd11:   return 64'h0000_0000_8000_000a;
      5'd12:   return 64'h0000_0000_8000_808b;
      5'd13:   return 64'h8000_0000_0000_008b;
      5'd14:   return 64'h8000_0000_0000_8089;
      5'd15:   return 64'h8000_0000_0000_8003;
      5'd16:   return 64'h8000_0000_0000_8002;
      5'd17:   return 64'h8000_0000_0000_0080;
      5'd18:   return 64'h0000_0000_0000_800a;
      5'd19:   return 64'h8000_0000_8000_000a;
      5'd20:   return 64'h8000_0000_8000_8081;
      5'd21:   return 64'h8000_0000_0000_8080;
      5'd22:   return 64'h0000_0000_8000_0001;
      5'd23:   return 64'h8000_0000_8000_8008;
      default: return 64'h0;
    endcase
  endfunction

endpackage

//--- rtl/keccak_round.sv
/* one keccak-f[1600] round, fully combinational. */
`timescale 1ns/1ps

module keccak_round
  import keccak_pkg::*;
(
  input  state_t in_state,
  input  word_t  round_const,
  output state_t out_state
);

  // lane index is x + 5*y, lane 0 in the top 64 bits.
  word_t a [25];
  word_t b [25];
  word_t e [25];
  word_t c [5];
  word_t d [5];

  // rho rotation amounts per lane.
  function automatic int rho_offset(int idx);
    case (idx)
      0:       return 0;
      1:       return 1;
      2:       return 62;
      3:       return 28;
      4:       return 27;
      5:       return 36;
      6:       return 44;
      7:       return 6;
      8:       return 55;
      9:       return 20;
      10:      return 3;
      11:      return 10;
      12:      return 43;
      13:      return 25;
      14:      return 39;
      15:      return 41;
      16:      return 45;
      17:      return 15;
      18:      return 21;
      19:      return 8;
      20:      return 18;
      21:      return 2;
      22:      return 61;
      23:      return 56;
      default: return 14;
    endcase
  endfunction

  function automatic word_t rotl(word_t v, int n);
    return (v << n) | (v >> (64 - n));
  endfunction

  always_comb
  begin
    for (int i = 0; i < 25; i++)
      a[i] = in_state[64*(24-i) +: 64];

    // theta column parities.
    for (int x = 0; x < 5; x++)
      c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
    for (int x = 0; x < 5; x++)
      d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);

    // rho and pi: lane (x,y) moves to (y, 2x+3y).
    for (int y = 0; y < 5; y++)
      for (int x = 0; x < 5; x++)
        b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y] ^ d[x], rho_offset(x + 5*y));

    // chi along each row.
    for (int y = 0; y < 5; y++)
      for (int x = 0; x < 5; x++)
        e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);

    // iota on lane zero only.
    e[0] = e[0] ^ round_const;

    for (int i = 0; i < 25; i++)
      out_state[64*(24-i) +: 64] = e[i];
  end

endmodule

//--- rtl/padder.sv
/* message padder: nine-word block buffer, keccak pad10*1
   insertion and block offer towards the permutation. */
`timescale 1ns/1ps

module padder
  import keccak_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  word_t     in,
  input  logic      in_ready,
  input  logic      is_last,
  input  byte_cnt_t byte_num,
  output logic      buffer_full,
  output block_t    block,
  output logic      block_ready,
  output logic      final_block,
  input  logic      ack
);

  padder_state_e state_q;
  logic [3:0]    cnt_q;
  logic          final_q;
  block_t        buf_q;
  word_t         next_word;
  word_t         keep_mask;
  word_t         pad_one;
  logic          accept;
  logic          shift_en;
  logic          last_word;

  // user words only enter while collecting.
  assign accept    = in_ready && (state_q == collecting);
  assign shift_en  = accept || (state_q == padding);
  assign last_word = (cnt_q == 4'(block_words - 1));

  // first byte is the top byte, so valid bytes are the upper ones.
  assign keep_mask = ~(64'hffff_ffff_ffff_ffff >> {byte_num, 3'b000});
  assign pad_one   = 64'h0100_0000_0000_0000 >> {byte_num, 3'b000};

  always_comb
  begin
    // padding cycles shift in zero words.
    next_word = '0;
    if (state_q == collecting)
    begin
      next_word = in;
      if (is_last)
        next_word = (in & keep_mask) | pad_one;
    end
    // closing bit of pad10*1, may merge into 0x81.
    if (last_word && (state_q == padding || is_last))
      next_word[7:0] = next_word[7:0] | 8'h80;
  end

  // block buffer, oldest word ends up on top.
  always_ff @(posedge clk)
  begin
    if (ack)
      buf_q <= '0;
    else if (shift_en)
      buf_q <= {buf_q[rate_bits-65:0], next_word};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= collecting;
      cnt_q   <= '0;
      final_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        collecting:
        begin
          if (accept)
          begin
            cnt_q <= cnt_q + 4'd1;
            if (is_last)
              final_q <= 1'b1;
            if (last_word)
              state_q <= offering;
            else if (is_last)
              state_q <= padding;
          end
        end
        padding:
        begin
          cnt_q <= cnt_q + 4'd1;
          if (last_word)
            state_q <= offering;
        end
        offering:
        begin
          if (ack)
          begin
            cnt_q   <= '0;
            state_q <= final_q ? done : collecting;
          end
        end
        default:
        begin
          // done: held until reset.
          state_q <= done;
        end
      endcase
    end
  end

  assign buffer_full = (state_q != collecting);
  assign block_ready = (state_q == offering);
  assign block       = buf_q;
  assign final_block = final_q;

  // a user word seen while full changes neither count nor buffer.
  assert property (@(posedge clk) disable iff (reset)
    (in_ready && buffer_full && state_q != padding && !ack)
      |=> $stable(cnt_q) && $stable(buf_q));

  assert property (@(posedge clk) disable iff (reset)
    cnt_q <= 4'(block_words));

endmodule

//--- tests/keccak_checker.sv
/* keccak-512 reference model with original padding, and checks of
   digest, out_ready and buffer_full against it. */
`timescale 1ns/1ps

module keccak_checker
  import keccak_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  word_t     in,
  input  logic      in_ready,
  input  logic      is_last,
  input  byte_cnt_t byte_num,
  input  logic      buffer_full,
  input  digest_t   out,
  input  logic      out_ready,
  output int        mismatches,
  output int        digests_checked
);

  localparam int rate_bytes = rate_bits / 8;

  logic [7:0]  msg [0:511];
  int          msg_len;
  logic        msg_done;
  logic        reset_q;
  logic        out_ready_q;
  logic [63:0] lane [0:24];
  logic [63:0] iota_tab [0:23];
  int          rho_tab [0:24];

  // iota constants from the lfsr, rho offsets from the lane walk.
  initial
  begin : build_tables
    logic [7:0] lfsr;
    int         x;
    int         y;
    int         tmp;
    mismatches      = 0;
    digests_checked = 0;
    reset_q         = 1'b0;
    out_ready_q     = 1'b0;
    msg_len         = 0;
    msg_done        = 1'b0;
    lfsr            = 8'h01;
    for (int r = 0; r < 24; r++)
    begin
      iota_tab[r] = '0;
      for (int j = 0; j < 7; j++)
      begin
        iota_tab[r][(1 << j) - 1] = lfsr[0];
        lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
      end
    end
    rho_tab[0] = 0;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++)
    begin
      rho_tab[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
      tmp = y;
      y   = (2*x + 3*y) % 5;
      x   = tmp;
    end
  end

  function automatic logic [63:0] rot_left(logic [63:0] v, int n);
    if (n == 0)
      return v;
    return (v << n) | (v >> (64 - n));
  endfunction

  // keccak-f[1600] on the model lanes.
  function automatic void permute();
    logic [63:0] c [0:4];
    logic [63:0] b [0:24];
    for (int r = 0; r < 24; r++)
    begin
      for (int x = 0; x < 5; x++)
        c[x] = lane[x] ^ lane[x+5] ^ lane[x+10] ^ lane[x+15] ^ lane[x+20];
      for (int i = 0; i < 25; i++)
        lane[i] = lane[i] ^ c[(i+4)%5] ^ rot_left(c[(i+1)%5], 1);
      for (int x = 0; x < 5; x++)
        for (int y = 0; y < 5; y++)
          b[y + 5*((2*x + 3*y) % 5)] = rot_left(lane[x + 5*y], rho_tab[x + 5*y]);
      for (int y = 0; y < 5; y++)
        for (int x = 0; x < 5; x++)
          lane[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
      lane[0] = lane[0] ^ iota_tab[r];
    end
  endfunction

  task automatic compute_digest(output digest_t dig);
    logic [7:0] padded [0:575];
    int         plen;
    plen = msg_len;
    for (int i = 0; i < plen; i++)
      padded[i] = msg[i];
    // 0x01 after the message, 0x80 on the last block byte.
    padded[plen] = 8'h01;
    plen++;
    while (plen % rate_bytes != 0)
    begin
      padded[plen] = 8'h00;
      plen++;
    end
    padded[plen-1] = padded[plen-1] | 8'h80;
    for (int i = 0; i < 25; i++)
      lane[i] = '0;
    for (int blk = 0; blk < plen / rate_bytes; blk++)
    begin
      for (int i = 0; i < rate_bytes; i++)
        lane[i/8][8*(i%8) +: 8] = lane[i/8][8*(i%8) +: 8] ^ padded[blk*rate_bytes + i];
      permute();
    end
    // digest byte 0 is the low byte of lane 0.
    for (int i = 0; i < digest_bits / 8; i++)
      dig[digest_bits-1-8*i -: 8] = lane[i/8][8*(i%8) +: 8];
  endtask

  always @(posedge clk)
  begin : watch
    digest_t expected;
    int      nb;
    if (reset)
    begin
      msg_len     = 0;
      msg_done    = 1'b0;
      out_ready_q = 1'b0;
    end
    else
    begin
      if (reset_q && (out_ready !== 1'b0 || buffer_full !== 1'b0))
      begin
        mismatches++;
        $display("FAIL out_ready/buffer_full after reset: got %h/%h expected 0/0",
                 out_ready, buffer_full);
      end
      if (msg_done && buffer_full !== 1'b1)
      begin
        mismatches++;
        $display("FAIL buffer_full: got %h expected 1", buffer_full);
      end
      if (out_ready_q && out_ready !== 1'b1)
      begin
        mismatches++;
        $display("FAIL out_ready: got %h expected 1", out_ready);
      end
      // only words the padder really takes.
      if (in_ready && buffer_full === 1'b0 && !msg_done)
      begin
        nb = is_last ? int'(byte_num) : 8;
        for (int k = 0; k < nb && msg_len < 512; k++)
        begin
          msg[msg_len] = in[63-8*k -: 8];
          msg_len++;
        end
        msg_done = is_last;
      end
      if (out_ready === 1'b1 && !out_ready_q)
      begin
        if (!msg_done)
        begin
          mismatches++;
          $display("out_ready rose before the final word was taken");
        end
        compute_digest(expected);
        digests_checked++;
        if (out !== expected)
        begin
          mismatches++;
          $display("FAIL out: got %h expected %h", out, expected);
        end
      end
      out_ready_q = (out_ready === 1'b1);
    end
    reset_q = reset;
  end

endmodule

//--- tests/tb_keccak.sv
/* keccak-512 testbench top: clock, reset, seeded random messages
   driven word by word, timeouts and the closing summary. */
`timescale 1ns/1ps

module tb_keccak
  import keccak_pkg::*;
();

  localparam int num_messages   = 40;
  localparam int full_timeout   = 200;
  localparam int digest_timeout = 2000;

  logic      clk;
  logic      reset;
  word_t     in;
  logic      in_ready;
  logic      is_last;
  byte_cnt_t byte_num;
  logic      buffer_full;
  digest_t   out;
  logic      out_ready;
  int        mismatches;
  int        digests_checked;
  int        timeouts;
  int        lengths [num_messages];

  always #10 clk = ~clk;

  keccak i_dut (
    .clk         (clk),
    .reset       (reset),
    .in          (in),
    .in_ready    (in_ready),
    .is_last     (is_last),
    .byte_num    (byte_num),
    .buffer_full (buffer_full),
    .out         (out),
    .out_ready   (out_ready)
  );

  keccak_checker i_checker (
    .clk             (clk),
    .reset           (reset),
    .in              (in),
    .in_ready        (in_ready),
    .is_last         (is_last),
    .byte_num        (byte_num),
    .buffer_full     (buffer_full),
    .out             (out),
    .out_ready       (out_ready),
    .mismatches      (mismatches),
    .digests_checked (digests_checked)
  );

  task automatic apply_reset();
    reset    = 1'b1;
    in_ready = 1'b0;
    is_last  = 1'b0;
    byte_num = '0;
    in       = '0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // holds the word until the padder can take it.
  task automatic send_word(word_t w, logic last, byte_cnt_t nb);
    int waited;
    waited   = 0;
    in       = w;
    in_ready = 1'b1;
    is_last  = last;
    byte_num = nb;
    while (buffer_full !== 1'b0 && waited < full_timeout)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (buffer_full !== 1'b0)
    begin
      timeouts++;
      $display("timeout: buffer_full stayed high while a word was waiting");
    end
    else
    begin
      @(posedge clk);
      #2;
    end
    in_ready = 1'b0;
    is_last  = 1'b0;
  endtask

  // idle cycles with junk on the data bus.
  task automatic idle_gap();
    repeat ($urandom_range(0, 3))
    begin
      in = {$urandom, $urandom};
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_message(int len);
    for (int w = 0; w < len / 8; w++)
    begin
      send_word({$urandom, $urandom}, 1'b0, '0);
      idle_gap();
    end
    // final word, invalid low bytes stay random.
    send_word({$urandom, $urandom}, 1'b1, byte_cnt_t'(len % 8));
    // strobes after the end must be ignored.
    in_ready = 1'b1;
    in       = {$urandom, $urandom};
    repeat (2) @(posedge clk);
    #2;
    in_ready = 1'b0;
  endtask

  task automatic wait_digest();
    int waited;
    waited = 0;
    while (out_ready !== 1'b1 && waited < digest_timeout)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (out_ready !== 1'b1)
    begin
      timeouts++;
      $display("timeout: out_ready never rose after the final word");
    end
    else
    begin
      // a few more cycles so the checker sees the flag held.
      repeat (3) @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    clk      = 1'b0;
    reset    = 1'b1;
    in       = '0;
    in_ready = 1'b0;
    is_last  = 1'b0;
    byte_num = '0;
    timeouts = 0;
    void'($urandom(32'hb6ebf620));
    // empty, short with every tail size, block edges, then long.
    lengths[0] = 0;
    for (int i = 1; i <= 16; i++)
      lengths[i] = 8 * $urandom_range(0, 8) + (i - 1) % 8;
    lengths[17] = 71;
    lengths[18] = 143;
    lengths[19] = 72;
    lengths[20] = 144;
    for (int i = 21; i < num_messages; i++)
      lengths[i] = $urandom_range(0, 400);
    for (int i = 0; i < num_messages; i++)
    begin
      apply_reset();
      send_message(lengths[i]);
      wait_digest();
    end
    if (digests_checked != num_messages)
      $display("only %0d of %0d digests were compared", digests_checked, num_messages);
    $display("summary: %0d mismatches, %0d timeouts, %0d digests compared",
             mismatches, timeouts, digests_checked);
    if (mismatches == 0 && timeouts == 0 && digests_checked == num_messages)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
